//--- include/tiled_rw_config.svh
// tiled rw widths and register map
`ifndef TILED_RW_CONFIG_SVH
`define TILED_RW_CONFIG_SVH

// ddr3 address geometry
`define TRW_ROW_BITS    15 // row address bits
`define TRW_COL8_BITS   7  // column bits in 8-bursts, one page is 128 of them
`define TRW_RC_BITS     22 // {row, col8} combined address

// frame geometry
`define TRW_FW_BITS     13 // frame width, in 8-bursts
`define TRW_FH_BITS     16 // frame height, in lines
`define TRW_TILE_BITS   6  // tile size field, counts go up to 64

// buffer and pipeline
`define TRW_BUF_PAGES   4  // on-chip buffer pages, also the credit limit
`define TRW_RECALC_LAT  7  // cycles from a token start to valid geometry

// register addresses
`define TRW_REG_MODE           4'd0 // {enable, run_n, write_mem}
`define TRW_REG_START_ADDR     4'd2 // {row, col8} of the frame start
`define TRW_REG_FULL_WIDTH     4'd3 // line pitch in 8-bursts
`define TRW_REG_WINDOW_WH      4'd4 // lo width, hi height
`define TRW_REG_WINDOW_X0Y0    4'd5 // lo left, hi top
`define TRW_REG_WINDOW_STARTXY 4'd6 // lo x, hi y relative to the window
`define TRW_REG_TILE_WH        4'd7 // lo tile cols, hi tile rows

`endif

//--- hw/tiled_rw_pkg.sv
// tiled rw types
`include "tiled_rw_config.svh"

package tiled_rw_pkg;

    typedef logic [`TRW_RC_BITS-1:0]            rc_addr_t; // {row, col8}
    typedef logic [`TRW_ROW_BITS-1:0]           row_t;
    typedef logic [`TRW_COL8_BITS-1:0]          col8_t;    // column in 8-bursts
    typedef logic [2:0]                         bank_t;
    typedef logic [`TRW_FW_BITS-1:0]            xpos_t;
    typedef logic [`TRW_FH_BITS-1:0]            ypos_t;
    typedef logic [`TRW_FW_BITS:0]              width_t;   // one extra bit for full width
    typedef logic [`TRW_FH_BITS:0]              height_t;
    typedef logic [`TRW_TILE_BITS:0]            tile_t;    // 1..64
    typedef logic [$clog2(`TRW_BUF_PAGES+1)-1:0] credit_t; // 0..4

    // parallel register write port
    typedef struct packed {
        logic        we;
        logic [3:0]  addr;
        logic [31:0] data;
    } reg_wr_t;

    // everything software programs, except mode
    typedef struct packed {
        rc_addr_t start_addr;
        width_t   full_width;    // pitch between 8-line groups
        width_t   window_width;
        height_t  window_height;
        xpos_t    window_x0;
        ypos_t    window_y0;
        xpos_t    start_x;       // relative to window
        ypos_t    start_y;
        tile_t    tile_cols;
        tile_t    tile_rows;
    } frame_cfg_t;

    typedef struct packed {
        logic enable;    // allow new requests
        logic run_n;     // high holds the channel in reset
        logic write_mem; // 1 writes to memory, 0 reads
    } mode_t;

    // stage 0..2 results
    typedef struct packed {
        xpos_t   frame_x;  // window_x0 + curr_x
        ypos_t   frame_y;  // window_y0 + curr_y
        height_t next_y;   // curr_y + tile_rows
        width_t  row_left; // columns left in the window row
        tile_t   num_cols; // clipped column count of the next transfer
    } geom_t;

    typedef struct packed {
        bank_t bank;
        row_t  row;
        col8_t col;
        tile_t cols_m1;
        tile_t rows_m1;
    } xfer_desc_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,   // walking tiles, requests allowed
        DRAIN  // last block issued, waiting for done
    } frame_state_e;

endpackage

//--- hw/tiled_rw_regs.sv
// frame parameter registers
`include "tiled_rw_config.svh"

module tiled_rw_regs
    import tiled_rw_pkg::*;
(
    input  logic       rst,         // clock
    input  logic       mclk,        // async reset
    input  reg_wr_t    reg_wr,
    output frame_cfg_t cfg,
    output mode_t      mode,
    output logic       cfg_written  // same cycle as the write
);
    logic [15:0] lo_w; // low word of the write data
    logic [15:0] hi_w; // high word
    logic        hit;  // write to a known address

    assign lo_w = reg_wr.data[15:0];
    assign hi_w = reg_wr.data[31:16];
    assign cfg_written = hit;

    always_comb begin
        hit = 1'b0;
        if (reg_wr.we) begin
            case (reg_wr.addr)
                `TRW_REG_MODE,
                `TRW_REG_START_ADDR,
                `TRW_REG_FULL_WIDTH,
                `TRW_REG_WINDOW_WH,
                `TRW_REG_WINDOW_X0Y0,
                `TRW_REG_WINDOW_STARTXY,
                `TRW_REG_TILE_WH:  hit = 1'b1;
                default:           hit = 1'b0; // unmapped, ignored
            endcase
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            cfg  <= '0;
            mode <= '0;
        end else if (hit) begin
            case (reg_wr.addr)
                `TRW_REG_MODE:       mode <= mode_t'(reg_wr.data[2:0]);
                `TRW_REG_START_ADDR: cfg.start_addr <= rc_addr_t'(reg_wr.data);
                `TRW_REG_FULL_WIDTH: cfg.full_width <= width_t'(lo_w);
                `TRW_REG_WINDOW_WH: begin
                    cfg.window_width  <= width_t'(lo_w);  // literal, no zero-is-max
                    cfg.window_height <= height_t'(hi_w);
                end
                `TRW_REG_WINDOW_X0Y0: begin
                    cfg.window_x0 <= xpos_t'(lo_w);
                    cfg.window_y0 <= ypos_t'(hi_w);
                end
                `TRW_REG_WINDOW_STARTXY: begin
                    cfg.start_x <= xpos_t'(lo_w); // loaded into curr_x on frame_start
                    cfg.start_y <= ypos_t'(hi_w);
                end
                `TRW_REG_TILE_WH: begin
                    cfg.tile_cols <= tile_t'(lo_w);
                    cfg.tile_rows <= tile_t'(hi_w);
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hw/tile_geometry.sv
// tile geometry stages
`include "tiled_rw_config.svh"

module tile_geometry
    import tiled_rw_pkg::*;
(
    input  logic                       rst,    // clock
    input  logic                       mclk,   // async reset
    input  frame_cfg_t                 cfg,
    input  xpos_t                      curr_x, // relative to window
    input  ypos_t                      curr_y,
    input  logic [`TRW_RECALC_LAT-1:0] recalc, // one-hot stage enables
    output geom_t                      geom
);
    localparam int PW = `TRW_COL8_BITS + 1; // page counts need 0..128

    typedef logic [PW-1:0] page_t;

    localparam page_t PAGE_COLS = page_t'(1 << `TRW_COL8_BITS);

    page_t page_left; // 8-bursts left in the ddr3 page at frame_x
    tile_t tile_lim;  // tile width limited by the row end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            geom      <= '0;
            page_left <= '0;
            tile_lim  <= '0;
        end else begin
            // stage 0, position in frame terms
            if (recalc[0]) begin
                geom.frame_x  <= cfg.window_x0 + curr_x;
                geom.frame_y  <= cfg.window_y0 + curr_y;
                geom.next_y   <= height_t'(curr_y) + height_t'(cfg.tile_rows);
                geom.row_left <= cfg.window_width - width_t'(curr_x);
            end
            // stage 1, two of the three limits
            if (recalc[1]) begin
                page_left <= PAGE_COLS - page_t'(geom.frame_x[`TRW_COL8_BITS-1:0]);
                tile_lim  <= (geom.row_left < width_t'(cfg.tile_cols)) ?
                             tile_t'(geom.row_left) : cfg.tile_cols;
            end
            // stage 2, page clip last
            if (recalc[2]) begin
                geom.num_cols <= (page_t'(tile_lim) > page_left) ?
                                 tile_t'(page_left) : tile_lim; // rest goes to next xfer
            end
        end
    end

endmodule

//--- hw/tile_address.sv
// transfer descriptor address stages
`include "tiled_rw_config.svh"

module tile_address
    import tiled_rw_pkg::*;
(
    input  logic                       rst,        // clock
    input  logic                       mclk,       // async reset, control flag only
    input  frame_cfg_t                 cfg,
    input  geom_t                      geom,
    input  logic [`TRW_RECALC_LAT-1:0] recalc,
    output xfer_desc_t                 desc,       // valid from token stage 6
    output logic                       last_in_row // valid from token stage 4
);
    localparam int YW = `TRW_FH_BITS - 3;     // frame_y without the bank bits
    localparam int MW = YW + `TRW_FW_BITS + 1; // full product width

    logic [YW-1:0] frame_y8_r;   // operand regs kept next to the multiplier
    width_t        full_width_r;
    rc_addr_t      start_addr_r;
    logic [MW-1:0] mul_w;
    rc_addr_t      mul_rslt;     // 8-line group offset, upper bits dropped
    rc_addr_t      line_start;   // {row, col8} of the line start
    rc_addr_t      row_col_w;

    assign mul_w     = MW'(frame_y8_r) * MW'(full_width_r);
    assign row_col_w = line_start + rc_addr_t'(geom.frame_x);

    // free running, so a dsp block can take the input and output regs
    always_ff @(posedge rst) begin
        frame_y8_r   <= geom.frame_y[`TRW_FH_BITS-1:3]; // valid from stage 2
        full_width_r <= cfg.full_width;
        start_addr_r <= cfg.start_addr;
        mul_rslt     <= mul_w[`TRW_RC_BITS-1:0];       // valid from stage 3
    end

    always_ff @(posedge rst) begin
        if (recalc[4]) begin
            line_start <= start_addr_r + mul_rslt;
        end
        if (recalc[5]) begin
            desc.row     <= row_col_w[`TRW_RC_BITS-1:`TRW_COL8_BITS];
            desc.col     <= row_col_w[`TRW_COL8_BITS-1:0];
            desc.bank    <= geom.frame_y[2:0]; // 8 consecutive lines go to 8 banks
            desc.cols_m1 <= geom.num_cols - 1'b1;
            desc.rows_m1 <= cfg.tile_rows - 1'b1;
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            last_in_row <= 1'b0;
        end else if (recalc[3]) begin
            last_in_row <= (width_t'(geom.num_cols) == geom.row_left); // page clip already in num_cols
        end
    end

endmodule

//--- hw/tile_sequencer.sv
// tile walk sequencer
`include "tiled_rw_config.svh"

module tile_sequencer
    import tiled_rw_pkg::*;
(
    input  logic                       rst,         // clock
    input  logic                       mclk,        // async reset
    input  frame_cfg_t                 cfg,
    input  mode_t                      mode,
    input  logic                       cfg_written,
    input  geom_t                      geom,
    input  logic                       last_in_row,
    input  logic                       frame_start,
    input  logic                       next_page,   // buffer side freed a page
    input  logic                       xfer_grant,
    input  logic                       xfer_done,
    output xpos_t                      curr_x,
    output ypos_t                      curr_y,
    output logic [`TRW_RECALC_LAT-1:0] recalc,      // token shifter
    output logic                       xfer_want,
    output logic                       xfer_need,
    output logic                       xfer_start,  // one cycle after grant
    output logic [1:0]                 xfer_page,
    output logic                       frame_done
);
    localparam int LAT = `TRW_RECALC_LAT;
    localparam credit_t FULL = credit_t'(`TRW_BUF_PAGES);

    frame_state_e   state;
    logic [LAT-1:0] valid_sr;   // fills with ones after the last token start
    credit_t        credits;    // free buffer pages
    credit_t        pending;    // started, not yet done
    logic           chn_rst;
    logic           chn_rst_d;
    logic           chn_en;
    logic           calc_valid;
    logic           trig;       // start a new token
    logic           last_block; // final transfer already issued
    logic           last_row;
    logic           pre_want;
    logic           done_w;

    assign chn_rst    = mode.run_n;
    assign chn_en     = mode.enable & ~mode.run_n;
    assign calc_valid = valid_sr[LAT-1];
    assign last_block = (state == DRAIN);
    assign last_row   = (geom.next_y >= cfg.window_height); // >= forgives odd heights
    // token follows the position update, so stage 0 sees the new curr_x
    assign trig       = xfer_start | frame_start | cfg_written | (chn_rst_d & ~chn_rst);
    assign pre_want   = (state == RUN) && chn_en && calc_valid && (credits != '0) &&
                        !xfer_start && !xfer_want && !last_block;
    assign done_w     = last_block && xfer_done && !xfer_start && (pending == credit_t'(1));

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            chn_rst_d <= 1'b0;
            recalc    <= '0;
            valid_sr  <= '0;
        end else begin
            chn_rst_d <= chn_rst;
            recalc    <= chn_rst ? '0 : {recalc[LAT-2:0], trig};
            if (chn_rst || trig)
                valid_sr <= '0;
            else
                valid_sr <= {valid_sr[LAT-2:0], 1'b1};
        end
    end

    // frame state
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            state <= IDLE;
        end else if (chn_rst) begin
            state <= IDLE;
        end else if (frame_start) begin
            state <= RUN; // restart even mid-frame
        end else begin
            case (state)
                RUN:     if (xfer_start && last_in_row && last_row) state <= DRAIN;
                DRAIN:   if (done_w) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // request, grant and start
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            xfer_want  <= 1'b0;
            xfer_need  <= 1'b0;
            xfer_start <= 1'b0;
        end else begin
            xfer_start <= xfer_grant & ~chn_rst;
            if (chn_rst || xfer_grant)
                xfer_want <= 1'b0;
            else if (pre_want)
                xfer_want <= 1'b1;
            if (chn_rst || xfer_grant)
                xfer_need <= 1'b0;
            else if (pre_want && (credits == FULL))
                xfer_need <= 1'b1; // buffer side is idle
        end
    end

    // credits and outstanding transfers
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            credits   <= '0;
            pending   <= '0;
            xfer_page <= '0;
        end else begin
            if (frame_start)
                credits <= mode.write_mem ? '0 : FULL; // write waits for filled pages
            else if (xfer_start && !next_page)
                credits <= credits - 1'b1;
            else if (!xfer_start && next_page && (credits != FULL))
                credits <= credits + 1'b1;
            if (chn_rst)
                pending <= '0;
            else if (xfer_start && !xfer_done)
                pending <= pending + 1'b1;
            else if (!xfer_start && xfer_done && (pending != '0))
                pending <= pending - 1'b1;
            if (xfer_done)
                xfer_page <= xfer_page + 1'b1; // wraps over the 4 pages
        end
    end

    // tile position and frame done
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            curr_x     <= '0;
            curr_y     <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= done_w;
            if (chn_rst || frame_start) begin
                curr_x <= cfg.start_x;
                curr_y <= cfg.start_y;
            end else if (xfer_start) begin
                curr_x <= last_in_row ? '0 : curr_x + xpos_t'(geom.num_cols);
                if (last_in_row)
                    curr_y <= geom.next_y[`TRW_FH_BITS-1:0]; // next tile row
            end
        end
    end

endmodule

//--- hw/tiled_rw_top.sv
// tiled rw channel top
`include "tiled_rw_config.svh"

module tiled_rw_top
    import tiled_rw_pkg::*;
(
    input  logic       rst,         // clock
    input  logic       mclk,        // async reset, active high
    input  reg_wr_t    reg_wr,
    input  logic       frame_start,
    input  logic       next_page,
    input  logic       xfer_grant,
    input  logic       xfer_done,
    output logic       xfer_want,
    output logic       xfer_need,
    output logic       xfer_start,
    output xfer_desc_t xfer_desc,   // valid with xfer_start
    output width_t     rowcol_inc,  // {row, col8} step to the next line group
    output logic [1:0] xfer_page,
    output logic       frame_done
);
    frame_cfg_t                 cfg;
    mode_t                      mode;
    logic                       cfg_written;
    geom_t                      geom;
    logic                       last_in_row;
    xpos_t                      curr_x;
    ypos_t                      curr_y;
    logic [`TRW_RECALC_LAT-1:0] recalc;

    assign rowcol_inc = cfg.full_width;

    tiled_rw_regs u_regs (
        .rst         (rst),
        .mclk        (mclk),
        .reg_wr      (reg_wr),
        .cfg         (cfg),
        .mode        (mode),
        .cfg_written (cfg_written)
    );

    tile_geometry u_geom (
        .rst    (rst),
        .mclk   (mclk),
        .cfg    (cfg),
        .curr_x (curr_x),
        .curr_y (curr_y),
        .recalc (recalc),
        .geom   (geom)
    );

    tile_address u_addr (
        .rst         (rst),
        .mclk        (mclk),
        .cfg         (cfg),
        .geom        (geom),
        .recalc      (recalc),
        .desc        (xfer_desc),
        .last_in_row (last_in_row)
    );

    tile_sequencer u_seq (
        .rst         (rst),
        .mclk        (mclk),
        .cfg         (cfg),
        .mode        (mode),
        .cfg_written (cfg_written),
        .geom        (geom),
        .last_in_row (last_in_row),
        .frame_start (frame_start),
        .next_page   (next_page),
        .xfer_grant  (xfer_grant),
        .xfer_done   (xfer_done),
        .curr_x      (curr_x),
        .curr_y      (curr_y),
        .recalc      (recalc),
        .xfer_want   (xfer_want),
        .xfer_need   (xfer_need),
        .xfer_start  (xfer_start),
        .xfer_page   (xfer_page),
        .frame_done  (frame_done)
    );

endmodule

//--- tests/tb_clock.sv
// testbench clock and reset
module tb_clock #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic arst  // active high
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2 arst = 1'b0; // released with the input drive delay
    end

endmodule

//--- tests/tiled_rw_chk.sv
// tiled rw protocol assertions
module tiled_rw_chk
    import tiled_rw_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input logic         xfer_grant,
    input logic         xfer_start,
    input logic         xfer_want,
    input logic         frame_done,
    input frame_state_e state      // sequencer frame state
);
    // start comes exactly one cycle after the grant
    a_start_after_grant: assert property (@(posedge clk) disable iff (reset)
        xfer_start == $past(xfer_grant))
        else $error("xfer_start not one cycle after xfer_grant");

    // no request outside a running frame
    a_want_only_busy: assert property (@(posedge clk) disable iff (reset)
        xfer_want |-> (state == RUN))
        else $error("xfer_want high while the frame is not running");

    // done is a single pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        frame_done |=> !frame_done)
        else $error("frame_done longer than one cycle");

endmodule

//--- tests/tiled_rw_tb.sv
// tiled rw channel testbench
`include "tiled_rw_config.svh"

module tiled_rw_tb
    import tiled_rw_pkg::*;
();
    typedef struct packed {
        int ww;   // window width, height
        int wh;
        int x0;   // window origin
        int y0;
        int sx;   // start inside window
        int sy;
        int tc;   // tile cols, rows
        int tr;
        int sa;   // start address {row, col8}
        int fw;   // full width
        bit wr;   // write mode
        bit hold; // withhold next_page
    } entry_t;

    localparam int N_FRAMES = 5;

    entry_t frames [N_FRAMES] = '{
        '{40, 16,   4, 8,  0, 0, 16, 8, 32'h001000,  64, 1'b0, 1'b0}, // plain read
        '{24,  8, 120, 0,  0, 0, 16, 8, 32'h020000, 256, 1'b0, 1'b0}, // page crossing
        '{64, 24,   0, 0,  0, 0, 16, 8, 32'h000300, 128, 1'b0, 1'b1}, // credit stall
        '{32, 16,  10, 3,  0, 0,  8, 4, 32'h001234, 100, 1'b1, 1'b0}, // write mode
        '{50, 12, 100, 5, 20, 4, 32, 4, 32'h004000, 200, 1'b0, 1'b0}  // start offset, clip
    };

    logic       clk;
    logic       arst;
    reg_wr_t    reg_wr;
    logic       frame_start;
    logic       next_page;
    logic       xfer_grant;
    logic       xfer_done;
    logic       xfer_want;
    logic       xfer_need;
    logic       xfer_start;
    xfer_desc_t xfer_desc;
    width_t     rowcol_inc;
    logic [1:0] xfer_page;
    logic       frame_done;

    xfer_desc_t exp_q[$]; // model descriptors of the current frame
    int value_errs = 0;
    int proto_errs = 0;
    int credits;          // model free pages
    int dones = 0;
    int fd_count = 0;     // frame_done pulses seen
    int wd_cycles = 0;

    tb_clock #(.PERIOD(20), .RST_CYCLES(3)) u_clk (.clk(clk), .arst(arst));

    tiled_rw_top dut (
        .rst(clk), .mclk(arst), .reg_wr(reg_wr), .frame_start(frame_start),
        .next_page(next_page), .xfer_grant(xfer_grant), .xfer_done(xfer_done),
        .xfer_want(xfer_want), .xfer_need(xfer_need), .xfer_start(xfer_start),
        .xfer_desc(xfer_desc), .rowcol_inc(rowcol_inc), .xfer_page(xfer_page),
        .frame_done(frame_done)
    );

    bind tiled_rw_top tiled_rw_chk u_chk (
        .clk(rst), .reset(mclk), .xfer_grant(xfer_grant), .xfer_start(xfer_start),
        .xfer_want(xfer_want), .frame_done(frame_done), .state(u_seq.state)
    );

    always @(posedge clk) if (frame_done) fd_count++; // sees the registered value

    task automatic next_cycle();
        @(posedge clk);
        #2; // drive and sample after the edge settles
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            proto_errs++;
        end
    endtask

    // reference walk over the window
    task automatic build_walk(input entry_t e);
        int x;
        int y;
        int fx;
        int fy;
        int rl;
        int pl;
        int nc;
        logic [21:0] a;
        xfer_desc_t d;
        bit lir;
        exp_q.delete();
        x = e.sx;
        y = e.sy;
        forever begin
            fx = e.x0 + x;
            fy = e.y0 + y;
            rl = e.ww - x;              // left in window row
            pl = 128 - (fx % 128);      // left in ddr3 page
            nc = e.tc;
            if (rl < nc) nc = rl;
            if (pl < nc) nc = pl;
            a = 22'(e.sa + (fy / 8) * e.fw + fx);
            d.bank    = 3'(fy % 8);
            d.row     = a[21:7];
            d.col     = a[6:0];
            d.cols_m1 = 7'(nc - 1);
            d.rows_m1 = 7'(e.tr - 1);
            exp_q.push_back(d);
            lir = (nc == rl);
            if (lir && (y + e.tr >= e.wh)) break; // last block
            if (lir) begin
                x = 0;
                y = y + e.tr;
            end else begin
                x = x + nc;
            end
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        reg_wr = '{we: 1'b1, addr: addr, data: data};
        next_cycle();
        reg_wr = '0;
    endtask

    task automatic pulse_next_page();
        next_page = 1'b1;
        next_cycle();
        next_page = 1'b0;
    endtask

    task automatic expect_no_want(input int n);
        repeat (n) begin
            next_cycle();
            check_true(!xfer_want && !xfer_start, "request or start without a free credit");
        end
    endtask

    task automatic wait_want(output bit ok);
        ok = xfer_want;
        for (int i = 0; i < 100 && !ok; i++) begin
            next_cycle();
            ok = xfer_want;
        end
    endtask

    task automatic run_entry(input int idx);
        entry_t e;
        int n;
        int d;
        bit ok;
        bit give_np;
        xfer_desc_t x;
        e = frames[idx];
        build_walk(e);
        n = exp_q.size();
        write_reg(`TRW_REG_START_ADDR, e.sa);
        write_reg(`TRW_REG_FULL_WIDTH, e.fw);
        write_reg(`TRW_REG_WINDOW_WH, {e.wh[15:0], e.ww[15:0]});
        write_reg(`TRW_REG_WINDOW_X0Y0, {e.y0[15:0], e.x0[15:0]});
        write_reg(`TRW_REG_WINDOW_STARTXY, {e.sy[15:0], e.sx[15:0]});
        write_reg(`TRW_REG_TILE_WH, {e.tr[15:0], e.tc[15:0]});
        write_reg(`TRW_REG_MODE, {29'd0, 1'b1, 1'b0, e.wr}); // enable, run
        frame_start = 1'b1;
        next_cycle();
        frame_start = 1'b0;
        credits = e.wr ? 0 : `TRW_BUF_PAGES;
        if (e.wr) begin
            expect_no_want(30);  // write waits for a filled page
            pulse_next_page();
            credits = 1;
        end
        for (int t = 0; t < n; t++) begin
            wait_want(ok);
            if (!ok) begin
                check_true(1'b0, "timed out waiting for xfer_want");
                return;
            end
            check_val("xfer_need", xfer_need, credits == `TRW_BUF_PAGES);
            d = $urandom_range(5, 0);
            repeat (d) begin
                next_cycle();
                check_true(xfer_want, "xfer_want dropped before the grant");
            end
            xfer_grant = 1'b1;
            next_cycle();
            xfer_grant = 1'b0;
            check_true(xfer_start, "no xfer_start one cycle after xfer_grant");
            x = exp_q[t];
            check_val("xfer_desc.bank", xfer_desc.bank, x.bank);
            check_val("xfer_desc.row", xfer_desc.row, x.row);
            check_val("xfer_desc.col", xfer_desc.col, x.col);
            check_val("xfer_desc.cols_m1", xfer_desc.cols_m1, x.cols_m1);
            check_val("xfer_desc.rows_m1", xfer_desc.rows_m1, x.rows_m1);
            check_val("rowcol_inc", rowcol_inc, e.fw);
            credits--;
            d = $urandom_range(4, 1);
            repeat (d) next_cycle();
            give_np = !(e.hold && t < 5); // first five starts run on the initial pages
            xfer_done = 1'b1;
            next_page = give_np;
            next_cycle();
            xfer_done = 1'b0;
            next_page = 1'b0;
            if (give_np && credits < `TRW_BUF_PAGES) credits++;
            dones++;
            check_val("frame_done", frame_done, t == n - 1);
            check_val("xfer_page", xfer_page, dones % 4);
            if (e.hold && (t == 3 || t == 4)) begin
                expect_no_want(40); // out of credits
                pulse_next_page();  // exactly one more start
                credits++;
            end
        end
        next_cycle();
        check_val("frame_done", frame_done, 0);
        expect_no_want(20); // nothing after the last block
    endtask

    // watchdog sized by the expected walk
    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int total;
        reg_wr      = '0;
        frame_start = 1'b0;
        next_page   = 1'b0;
        xfer_grant  = 1'b0;
        xfer_done   = 1'b0;
        void'($urandom(32'hb475_b709));
        total = 0;
        for (int i = 0; i < N_FRAMES; i++) begin
            build_walk(frames[i]);
            total += exp_q.size();
        end
        wd_cycles = total * 40 + N_FRAMES * 300 + 200;
        wait (!arst);
        repeat (10) begin // idle after reset
            next_cycle();
            check_true(!xfer_want && !xfer_need && !xfer_start && !frame_done,
                       "control output active before any frame_start");
            check_val("xfer_page", xfer_page, 0);
        end
        for (int i = 0; i < N_FRAMES; i++) run_entry(i);
        next_cycle();
        check_val("frame_done count", fd_count, N_FRAMES);
        $display("errors: %0d value mismatches, %0d protocol failures", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tiled_rw.f
+incdir+include
hw/tiled_rw_pkg.sv
hw/tiled_rw_regs.sv
hw/tile_geometry.sv
hw/tile_address.sv
hw/tile_sequencer.sv
hw/tiled_rw_top.sv
tests/tb_clock.sv
tests/tiled_rw_chk.sv
tests/tiled_rw_tb.sv

//--- Makefile
# Verilator build and run for the tiled rw channel

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

obj_dir/Vtiled_rw_tb: tiled_rw.f include/*.svh hw/*.sv tests/*.sv
	verilator --binary --timing -f tiled_rw.f --top-module tiled_rw_tb -o Vtiled_rw_tb

test: obj_dir/Vtiled_rw_tb
	./obj_dir/Vtiled_rw_tb | tee sim.log
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
